/* rtl/rv_core_consts.svh */
`ifndef RV_CORE_CONSTS_SVH
`define RV_CORE_CONSTS_SVH

// Data and address width
`define XLEN 32

`define REG_COUNT 32

// Program memory depth in words
`define IMEM_DEPTH 32

// Clock cycles between two instruction issues
`define STAGE_CYCLES 5

`endif

/* rtl/rv_isa_pkg.sv */
package rv_isa_pkg;

    typedef enum logic [6:0] {
        OPC_OP     = 7'b0110011,
        OPC_OP_IMM = 7'b0010011,
        OPC_LUI    = 7'b0110111,
        OPC_AUIPC  = 7'b0010111,
        OPC_BRANCH = 7'b1100011,
        OPC_JAL    = 7'b1101111,
        OPC_JALR   = 7'b1100111,
        OPC_LOAD   = 7'b0000011,
        OPC_STORE  = 7'b0100011
    } opcode_e;

    localparam logic [2:0] F3_ADD  = 3'b000;  // Also SUB
    localparam logic [2:0] F3_SLL  = 3'b001;
    localparam logic [2:0] F3_SLT  = 3'b010;
    localparam logic [2:0] F3_SLTU = 3'b011;
    localparam logic [2:0] F3_XOR  = 3'b100;
    localparam logic [2:0] F3_SR   = 3'b101;  // SRL or SRA
    localparam logic [2:0] F3_OR   = 3'b110;
    localparam logic [2:0] F3_AND  = 3'b111;

    localparam logic [2:0] F3_BEQ  = 3'b000;
    localparam logic [2:0] F3_BNE  = 3'b001;
    localparam logic [2:0] F3_BLT  = 3'b100;
    localparam logic [2:0] F3_BGE  = 3'b101;
    localparam logic [2:0] F3_BLTU = 3'b110;
    localparam logic [2:0] F3_BGEU = 3'b111;

    localparam logic [6:0] F7_ALT  = 7'b0100000;  // SUB, SRA, SRAI

    typedef struct packed {
        logic [6:0] funct7;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] rd;
        opcode_e    opcode;
    } r_fmt_t;

    typedef struct packed {
        logic [11:0] imm;
        logic [4:0]  rs1;
        logic [2:0]  funct3;
        logic [4:0]  rd;
        opcode_e     opcode;
    } i_fmt_t;

    typedef struct packed {
        logic [6:0] imm_hi;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] imm_lo;
        opcode_e    opcode;
    } s_fmt_t;

    typedef struct packed {
        logic       imm12;
        logic [5:0] imm10_5;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [3:0] imm4_1;
        logic       imm11;
        opcode_e    opcode;
    } b_fmt_t;

    typedef struct packed {
        logic [19:0] imm;
        logic [4:0]  rd;
        opcode_e     opcode;
    } u_fmt_t;

    typedef struct packed {
        logic       imm20;
        logic [9:0] imm10_1;
        logic       imm11;
        logic [7:0] imm19_12;
        logic [4:0] rd;
        opcode_e    opcode;
    } j_fmt_t;

    typedef union packed {
        r_fmt_t r;
        i_fmt_t i;
        s_fmt_t s;
        b_fmt_t b;
        u_fmt_t u;
        j_fmt_t j;
    } instr_u;

endpackage

/* rtl/core_pkg.sv */
package core_pkg;

    // What execute does with a decoded instruction
    typedef enum logic [2:0] {
        CL_ALU,
        CL_LUI,
        CL_AUIPC,
        CL_BRANCH,
        CL_JAL,
        CL_JALR,
        CL_NOP
    } op_class_e;

    typedef enum logic [3:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_SLL,
        ALU_SLT,
        ALU_SLTU,
        ALU_XOR,
        ALU_SRL,
        ALU_SRA,
        ALU_OR,
        ALU_AND
    } alu_op_e;

endpackage

/* rtl/decode_if.sv */
`timescale 1ns/1ps
`include "rv_core_consts.svh"

interface decode_if;
    import core_pkg::*;

    logic                          valid;
    logic [`XLEN-1:0]              pc;
    op_class_e                     op_class;
    alu_op_e                       alu_op;
    logic [`XLEN-1:0]              rs1_val;
    logic [`XLEN-1:0]              rs2_val;   // Immediate for OP-IMM
    logic [`XLEN-1:0]              imm;       // Branch, jump or upper immediate
    logic [$clog2(`REG_COUNT)-1:0] rd;
    logic [2:0]                    br_funct;

    modport src (
        output valid, pc, op_class, alu_op, rs1_val, rs2_val, imm, rd, br_funct
    );

    modport dst (
        input valid, pc, op_class, alu_op, rs1_val, rs2_val, imm, rd, br_funct
    );

endinterface

/* rtl/reg_file.sv */
`timescale 1ns/1ps
`include "rv_core_consts.svh"

module reg_file (
    input  logic                          clk,
    input  logic                          rst,
    input  logic [$clog2(`REG_COUNT)-1:0] rs1_addr,
    input  logic [$clog2(`REG_COUNT)-1:0] rs2_addr,
    input  logic                          we,
    input  logic [$clog2(`REG_COUNT)-1:0] rd,
    input  logic [`XLEN-1:0]              data,
    output logic [`XLEN-1:0]              rs1_val,
    output logic [`XLEN-1:0]              rs2_val
);
    logic [`XLEN-1:0] regs [`REG_COUNT];

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < `REG_COUNT; i++) begin
                regs[i] <= '0;
            end
        end else if (we && rd != '0) begin
            regs[rd] <= data;       // x0 never written
        end
    end

    assign rs1_val = regs[rs1_addr];
    assign rs2_val = regs[rs2_addr];

    // x0 stays zero through reset and every write
    a_x0_zero: assert property (
        @(posedge clk) disable iff (rst)
        (rs1_addr == '0 |-> rs1_val == '0) and (rs2_addr == '0 |-> rs2_val == '0)
    );

endmodule

/* rtl/fetch_unit.sv */
`timescale 1ns/1ps
`include "rv_core_consts.svh"

module fetch_unit (
    input  logic                           clk,
    input  logic                           rst,
    input  logic                           prog_we,
    input  logic [$clog2(`IMEM_DEPTH)-1:0] prog_addr,
    input  logic [`XLEN-1:0]               prog_data,
    input  logic                           start,
    input  logic                           redirect_valid,
    input  logic [`XLEN-1:0]               redirect_pc,
    output logic                           busy,
    output logic                           issue_valid,
    output logic [`XLEN-1:0]               issue_pc,
    output rv_isa_pkg::instr_u             issue_instr
);
    import rv_isa_pkg::*;

    localparam int AW    = $clog2(`IMEM_DEPTH);
    localparam int CNT_W = $clog2(`STAGE_CYCLES);

    instr_u           imem [`IMEM_DEPTH];
    logic [`XLEN-1:0] pc;        // Next word to issue
    logic [CNT_W-1:0] pace_cnt;
    logic             issue_now;
    logic [`XLEN-1:0] fetch_pc;
    logic             in_range;

    assign issue_now = start || (busy && pace_cnt == CNT_W'(`STAGE_CYCLES - 1));
    assign fetch_pc  = start ? '0 : pc;   // Start always begins at word 0
    assign in_range  = fetch_pc[`XLEN-1:2] < `IMEM_DEPTH;

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < `IMEM_DEPTH; i++) begin
                imem[i] <= '0;
            end
        end else if (prog_we && !busy) begin
            imem[prog_addr] <= prog_data;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            busy        <= 1'b0;
            issue_valid <= 1'b0;
            pc          <= '0;
            pace_cnt    <= '0;
        end else begin
            issue_valid <= 1'b0;
            if (busy) begin
                pace_cnt <= pace_cnt + 1'b1;
            end
            if (redirect_valid) begin
                pc <= redirect_pc;       // Lands before the next issue
            end
            if (issue_now) begin
                pace_cnt <= '0;
                if (in_range) begin
                    busy        <= 1'b1;
                    issue_valid <= 1'b1;
                    pc          <= fetch_pc + 4;
                end else begin
                    busy <= 1'b0;        // Ran off the end of memory
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (issue_now && in_range) begin
            issue_pc    <= fetch_pc;
            issue_instr <= imem[fetch_pc[AW+1:2]];
        end
    end

    a_issue_needs_busy: assert property (
        @(posedge clk) disable iff (rst) $rose(issue_valid) |-> busy
    );

endmodule

/* rtl/decode_unit.sv */
`timescale 1ns/1ps
`include "rv_core_consts.svh"

module decode_unit (
    input  logic                          clk,
    input  logic                          rst,
    input  logic                          issue_valid,
    input  logic [`XLEN-1:0]              issue_pc,
    input  rv_isa_pkg::instr_u            issue_instr,
    input  logic                          rf_we,
    input  logic [$clog2(`REG_COUNT)-1:0] rf_rd,
    input  logic [`XLEN-1:0]              rf_data,
    decode_if.src                         dif
);
    import rv_isa_pkg::*;
    import core_pkg::*;

    op_class_e        op_class;
    alu_op_e          alu_op;
    logic [`XLEN-1:0] imm_ext;
    logic             use_imm;
    logic [`XLEN-1:0] rs1_val;
    logic [`XLEN-1:0] rs2_val;

    function automatic alu_op_e alu_decode(input logic [2:0] f3, input logic alt);
        alu_op_e op;
        case (f3)
            F3_ADD:  op = alt ? ALU_SUB : ALU_ADD;
            F3_SLL:  op = ALU_SLL;
            F3_SLT:  op = ALU_SLT;
            F3_SLTU: op = ALU_SLTU;
            F3_XOR:  op = ALU_XOR;
            F3_SR:   op = alt ? ALU_SRA : ALU_SRL;
            F3_OR:   op = ALU_OR;
            default: op = ALU_AND;
        endcase
        return op;
    endfunction

    reg_file u_rf (
        .clk      (clk),
        .rst      (rst),
        .rs1_addr (issue_instr.r.rs1),
        .rs2_addr (issue_instr.r.rs2),
        .we       (rf_we),
        .rd       (rf_rd),
        .data     (rf_data),
        .rs1_val  (rs1_val),
        .rs2_val  (rs2_val)
    );

    always_comb begin
        op_class = CL_NOP;
        alu_op   = ALU_ADD;
        imm_ext  = '0;
        use_imm  = 1'b0;
        case (issue_instr.r.opcode)
            OPC_OP: begin
                op_class = CL_ALU;
                alu_op   = alu_decode(issue_instr.r.funct3, issue_instr.r.funct7 == F7_ALT);
            end
            OPC_OP_IMM: begin
                op_class = CL_ALU;
                use_imm  = 1'b1;
                // Upper immediate bits select SRAI only for shifts right
                alu_op   = alu_decode(issue_instr.i.funct3,
                    issue_instr.i.funct3 == F3_SR && issue_instr.r.funct7 == F7_ALT);
                imm_ext  = {{(`XLEN-12){issue_instr.i.imm[11]}}, issue_instr.i.imm};
            end
            OPC_LUI, OPC_AUIPC: begin
                op_class = (issue_instr.u.opcode == OPC_LUI) ? CL_LUI : CL_AUIPC;
                imm_ext  = {issue_instr.u.imm, 12'b0};
            end
            OPC_BRANCH: begin
                op_class = CL_BRANCH;
                imm_ext  = {{(`XLEN-12){issue_instr.b.imm12}}, issue_instr.b.imm11,
                    issue_instr.b.imm10_5, issue_instr.b.imm4_1, 1'b0};
            end
            OPC_JAL: begin
                op_class = CL_JAL;
                imm_ext  = {{(`XLEN-20){issue_instr.j.imm20}}, issue_instr.j.imm19_12,
                    issue_instr.j.imm11, issue_instr.j.imm10_1, 1'b0};
            end
            OPC_JALR: begin
                op_class = CL_JALR;
                imm_ext  = {{(`XLEN-12){issue_instr.i.imm[11]}}, issue_instr.i.imm};
            end
            OPC_LOAD, OPC_STORE: op_class = CL_NOP;   // Retire as no-ops
            default:             op_class = CL_NOP;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            dif.valid <= 1'b0;
        end else begin
            dif.valid <= issue_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (issue_valid) begin
            dif.pc       <= issue_pc;
            dif.op_class <= op_class;
            dif.alu_op   <= alu_op;
            dif.rs1_val  <= rs1_val;
            dif.rs2_val  <= use_imm ? imm_ext : rs2_val;
            dif.imm      <= imm_ext;
            dif.rd       <= issue_instr.r.rd;
            dif.br_funct <= issue_instr.b.funct3;
        end
    end

    // Relies on fetch pacing issues apart
    a_valid_strobe: assert property (
        @(posedge clk) disable iff (rst) dif.valid |=> !dif.valid
    );

endmodule

/* rtl/execute_unit.sv */
`timescale 1ns/1ps
`include "rv_core_consts.svh"

module execute_unit (
    input  logic                          clk,
    input  logic                          rst,
    decode_if.dst                         dif,
    output logic                          rf_we,
    output logic [$clog2(`REG_COUNT)-1:0] rf_rd,
    output logic [`XLEN-1:0]              rf_data,
    output logic                          redirect_valid,
    output logic [`XLEN-1:0]              redirect_pc,
    output logic                          wb_valid,
    output logic [`XLEN-1:0]              wb_pc,
    output logic [$clog2(`REG_COUNT)-1:0] wb_rd,
    output logic [`XLEN-1:0]              wb_data
);
    import rv_isa_pkg::*;
    import core_pkg::*;

    logic [4:0]       shamt;
    logic [`XLEN-1:0] alu_res;
    logic             br_take;
    logic [`XLEN-1:0] link;
    logic [`XLEN-1:0] result;
    logic [`XLEN-1:0] target;
    logic             writes;
    logic             take;

    assign shamt = dif.rs2_val[4:0];
    assign link  = dif.pc + 4;

    always_comb begin
        case (dif.alu_op)
            ALU_ADD:  alu_res = dif.rs1_val + dif.rs2_val;
            ALU_SUB:  alu_res = dif.rs1_val - dif.rs2_val;
            ALU_SLL:  alu_res = dif.rs1_val << shamt;
            ALU_SLT:  alu_res = {{(`XLEN-1){1'b0}},
                                 $signed(dif.rs1_val) < $signed(dif.rs2_val)};
            ALU_SLTU: alu_res = {{(`XLEN-1){1'b0}}, dif.rs1_val < dif.rs2_val};
            ALU_XOR:  alu_res = dif.rs1_val ^ dif.rs2_val;
            ALU_SRL:  alu_res = dif.rs1_val >> shamt;
            ALU_SRA:  alu_res = $unsigned($signed(dif.rs1_val) >>> shamt);
            ALU_OR:   alu_res = dif.rs1_val | dif.rs2_val;
            default:  alu_res = dif.rs1_val & dif.rs2_val;
        endcase
    end

    always_comb begin
        case (dif.br_funct)
            F3_BEQ:  br_take = dif.rs1_val == dif.rs2_val;
            F3_BNE:  br_take = dif.rs1_val != dif.rs2_val;
            F3_BLT:  br_take = $signed(dif.rs1_val) < $signed(dif.rs2_val);
            F3_BGE:  br_take = $signed(dif.rs1_val) >= $signed(dif.rs2_val);
            F3_BLTU: br_take = dif.rs1_val < dif.rs2_val;
            F3_BGEU: br_take = dif.rs1_val >= dif.rs2_val;
            default: br_take = 1'b0;   // Reserved encodings fall through
        endcase
    end

    always_comb begin
        result = alu_res;
        target = dif.pc + dif.imm;
        writes = 1'b0;
        take   = 1'b0;
        case (dif.op_class)
            CL_ALU:    writes = 1'b1;
            CL_LUI: begin
                result = dif.imm;
                writes = 1'b1;
            end
            CL_AUIPC: begin
                result = dif.pc + dif.imm;
                writes = 1'b1;
            end
            CL_BRANCH: take = br_take;
            CL_JAL: begin
                result = link;
                writes = 1'b1;
                take   = 1'b1;
            end
            CL_JALR: begin
                result = link;
                target = (dif.rs1_val + dif.imm) & ~`XLEN'(1);
                writes = 1'b1;
                take   = 1'b1;
            end
            default: ;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            wb_valid       <= 1'b0;
            redirect_valid <= 1'b0;
        end else begin
            wb_valid       <= dif.valid && writes && dif.rd != '0;
            redirect_valid <= dif.valid && take;
        end
    end

    always_ff @(posedge clk) begin
        if (dif.valid) begin
            wb_pc       <= dif.pc;
            wb_rd       <= dif.rd;
            wb_data     <= result;
            redirect_pc <= target;
        end
    end

    // Register write shares the retirement record
    assign rf_we   = wb_valid;
    assign rf_rd   = wb_rd;
    assign rf_data = wb_data;

endmodule

/* rtl/rv_core_top.sv */
`timescale 1ns/1ps
`include "rv_core_consts.svh"

module rv_core_top (
    input  logic                          clk,
    input  logic                          rst,
    input  logic                          prog_we,
    input  logic [$clog2(`IMEM_DEPTH)-1:0] prog_addr,
    input  logic [`XLEN-1:0]              prog_data,
    input  logic                          start,
    output logic                          busy,
    output logic                          wb_valid,
    output logic [`XLEN-1:0]              wb_pc,
    output logic [$clog2(`REG_COUNT)-1:0] wb_rd,
    output logic [`XLEN-1:0]              wb_data
);
    import rv_isa_pkg::*;

    logic                          issue_valid;
    logic [`XLEN-1:0]              issue_pc;
    instr_u                        issue_instr;
    logic                          redirect_valid;
    logic [`XLEN-1:0]              redirect_pc;
    logic                          rf_we;
    logic [$clog2(`REG_COUNT)-1:0] rf_rd;
    logic [`XLEN-1:0]              rf_data;

    decode_if dif ();

    fetch_unit u_fetch (
        .clk            (clk),
        .rst            (rst),
        .prog_we        (prog_we),
        .prog_addr      (prog_addr),
        .prog_data      (prog_data),
        .start          (start),
        .redirect_valid (redirect_valid),
        .redirect_pc    (redirect_pc),
        .busy           (busy),
        .issue_valid    (issue_valid),
        .issue_pc       (issue_pc),
        .issue_instr    (issue_instr)
    );

    decode_unit u_decode (
        .clk         (clk),
        .rst         (rst),
        .issue_valid (issue_valid),
        .issue_pc    (issue_pc),
        .issue_instr (issue_instr),
        .rf_we       (rf_we),
        .rf_rd       (rf_rd),
        .rf_data     (rf_data),
        .dif         (dif.src)
    );

    execute_unit u_execute (
        .clk            (clk),
        .rst            (rst),
        .dif            (dif.dst),
        .rf_we          (rf_we),
        .rf_rd          (rf_rd),
        .rf_data        (rf_data),
        .redirect_valid (redirect_valid),
        .redirect_pc    (redirect_pc),
        .wb_valid       (wb_valid),
        .wb_pc          (wb_pc),
        .wb_rd          (wb_rd),
        .wb_data        (wb_data)
    );

endmodule

/* verif/tb_clock_gen.sv */
`timescale 1ns/1ps

module tb_clock_gen #(
    parameter int PERIOD_NS = 100
) (
    output logic clk
);
    initial begin
        clk = 1'b0;
        forever begin
            #(PERIOD_NS / 2) clk = ~clk;
        end
    end

endmodule

/* verif/tb_rv_core.sv */
`timescale 1ns/1ps
`include "rv_core_consts.svh"

module tb_rv_core;
    import rv_isa_pkg::*;

    localparam int AW            = $clog2(`IMEM_DEPTH);
    localparam int RW            = $clog2(`REG_COUNT);
    localparam int VEC_WORDS     = 1024;
    localparam int MARGIN_CYCLES = 100;

    logic             clk;
    logic             rst;
    logic             prog_we;
    logic [AW-1:0]    prog_addr;
    logic [`XLEN-1:0] prog_data;
    logic             start;
    logic             busy;
    logic             wb_valid;
    logic [`XLEN-1:0] wb_pc;
    logic [RW-1:0]    wb_rd;
    logic [`XLEN-1:0] wb_data;

    logic [`XLEN-1:0] vec [VEC_WORDS];
    logic [`XLEN-1:0] got_pc [$];
    logic [RW-1:0]    got_rd [$];
    logic [`XLEN-1:0] got_data [$];
    time              got_time [$];
    int               limit_cycles = 0;

    tb_clock_gen #(.PERIOD_NS(100)) u_clk (.clk(clk));

    rv_core_top UUT (
        .clk       (clk),
        .rst       (rst),
        .prog_we   (prog_we),
        .prog_addr (prog_addr),
        .prog_data (prog_data),
        .start     (start),
        .busy      (busy),
        .wb_valid  (wb_valid),
        .wb_pc     (wb_pc),
        .wb_rd     (wb_rd),
        .wb_data   (wb_data)
    );

    // LOAD word with the address above the opcode retires as a no-op
    function automatic logic [`XLEN-1:0] fill_word(input int a);
        return (`XLEN'(a) << 7) | `XLEN'(7'b0000011);
    endfunction

    // Padded programs make every run issue the whole memory
    function automatic int compute_limit();
        int pos;
        int total;
        pos   = 0;
        total = MARGIN_CYCLES;
        while (pos < VEC_WORDS - 4 && !$isunknown(vec[pos]) && vec[pos] != '0) begin
            total += int'(vec[pos+3]) * `IMEM_DEPTH * `STAGE_CYCLES * 4 + `IMEM_DEPTH;
            pos += 4 + int'(vec[pos+1]) + 3 * int'(vec[pos+2]);
        end
        return total;
    endfunction

    task automatic load_program(input int base, input int nwords);
        for (int a = 0; a < `IMEM_DEPTH; a++) begin
            @(negedge clk);
            prog_we   = 1'b1;
            prog_addr = AW'(a);
            prog_data = (a < nwords) ? vec[base + a] : fill_word(a);
        end
        @(negedge clk);
        prog_we = 1'b0;
    endtask

    task automatic run_program(output int errs);
        errs = 0;
        got_pc.delete();
        got_rd.delete();
        got_data.delete();
        got_time.delete();
        @(negedge clk);
        start = 1'b1;
        @(negedge clk);
        start = 1'b0;
        if (busy !== 1'b1) begin
            $display("CHECK FAILED t=%0t busy expected 1 got %b", $time, busy);
            errs++;
        end
        while (!busy) @(negedge clk);
        while (busy) @(negedge clk);
    endtask

    task automatic compare_run(input int prog_base, input int nwords, input int rec_base,
                               input int nrec, input int run_idx, output int errs);
        int               n;
        int               idx;
        logic [`XLEN-1:0] exp_pc;
        logic [RW-1:0]    exp_rd;
        logic [`XLEN-1:0] exp_data;
        opcode_e          opc;
        string            opname;
        errs = 0;
        n = (got_pc.size() > nrec) ? got_pc.size() : nrec;
        for (int i = 0; i < n; i++) begin
            if (i >= got_pc.size()) begin
                $display("Run %0d is missing record %0d, expected a write to x%0d at pc %h",
                    run_idx, i, vec[rec_base + 3*i + 1][RW-1:0], vec[rec_base + 3*i]);
                errs++;
            end else if (i >= nrec) begin
                $display("Run %0d has an extra record %0d at t=%0t, x%0d written at pc %h",
                    run_idx, i, got_time[i], got_rd[i], got_pc[i]);
                errs++;
            end else begin
                exp_pc   = vec[rec_base + 3*i];
                exp_rd   = vec[rec_base + 3*i + 1][RW-1:0];
                exp_data = vec[rec_base + 3*i + 2];
                idx      = int'(exp_pc[AW+1:2]);
                if (idx < nwords) begin
                    opc    = opcode_e'(vec[prog_base + idx][6:0]);
                    opname = opc.name();
                end else begin
                    opname = "";
                end
                if (got_pc[i] !== exp_pc) begin
                    $display("CHECK FAILED t=%0t wb_pc expected %h got %h",
                        got_time[i], exp_pc, got_pc[i]);
                    errs++;
                end
                if (got_rd[i] !== exp_rd) begin
                    $display("CHECK FAILED t=%0t wb_rd expected %0d got %0d (pc %h, %s)",
                        got_time[i], exp_rd, got_rd[i], exp_pc, opname);
                    errs++;
                end
                if (got_data[i] !== exp_data) begin
                    $display("CHECK FAILED t=%0t wb_data expected %h got %h (pc %h, %s)",
                        got_time[i], exp_data, got_data[i], exp_pc, opname);
                    errs++;
                end
            end
        end
    endtask

    always @(negedge clk) begin
        if (!rst && wb_valid === 1'b1) begin
            got_pc.push_back(wb_pc);
            got_rd.push_back(wb_rd);
            got_data.push_back(wb_data);
            got_time.push_back($time);
        end
    end

    initial begin
        wait (limit_cycles > 0);
        repeat (limit_cycles) @(posedge clk);
        $display("Timeout after %0d cycles, the core never finished its programs",
            limit_cycles);
        $display(">>> FAIL");
        $finish;
    end

    initial begin
        int          pos;
        logic [31:0] name;
        int          nwords;
        int          nrec;
        int          nruns;
        int          prog_base;
        int          rec_base;
        int          start_errs;
        int          run_errs;
        int          test_errs;
        int          errors;
        int          tests_run;
        int          tests_failed;
        bit          setup_err;

        rst          = 1'b1;
        prog_we      = 1'b0;
        prog_addr    = '0;
        prog_data    = '0;
        start        = 1'b0;
        errors       = 0;
        tests_run    = 0;
        tests_failed = 0;
        setup_err    = 1'b0;

        $readmemh("verif/rv_core_vectors.txt", vec);
        if ($isunknown(vec[0])) begin
            $display("Vectors file could not be read or is empty");
            setup_err = 1'b1;
        end else begin
            limit_cycles = compute_limit();
        end

        repeat (5) @(negedge clk);
        rst = 1'b0;

        pos = 0;
        while (!setup_err && pos < VEC_WORDS - 4 && !$isunknown(vec[pos]) && vec[pos] != '0) begin
            name      = vec[pos];
            nwords    = int'(vec[pos+1]);
            nrec      = int'(vec[pos+2]);
            nruns     = int'(vec[pos+3]);
            prog_base = pos + 4;
            rec_base  = prog_base + nwords;
            if (nwords > `IMEM_DEPTH || nruns < 1) begin
                $display("Block %s at word %0d has a bad header", name, pos);
                setup_err = 1'b1;
            end else begin
                test_errs = 0;
                load_program(prog_base, nwords);
                for (int r = 0; r < nruns; r++) begin
                    run_program(start_errs);      // Later runs restart from pc 0
                    compare_run(prog_base, nwords, rec_base, nrec, r, run_errs);
                    test_errs += start_errs + run_errs;
                end
                tests_run++;
                if (test_errs != 0) begin
                    tests_failed++;
                end
                errors += test_errs;
                $display("Test %s: %0d run(s), %0d records each, %s",
                    name, nruns, nrec, (test_errs == 0) ? "ok" : "FAILED");
                pos = rec_base + 3 * nrec;
            end
        end

        if (!setup_err && tests_run == 0) begin
            $display("No test blocks found in the vectors file");
            setup_err = 1'b1;
        end

        $display("Tests run %0d, tests failed %0d, check errors %0d",
            tests_run, tests_failed, errors);
        if (errors == 0 && !setup_err) begin
            $display(">>> PASS");
        end else begin
            $display(">>> FAIL");
        end
        $finish;
    end

endmodule

/* verif/rv_core_vectors.txt */
// Block header: name (4 ASCII chars), word count, record count, run count
// Then the program words, then one record per triple: pc rd value. Name 0 ends the file
// RALU: R-type ALU, signed and unsigned on negative operands
52414C55 0000000C 0000000C 00000001
00700093 FFD00113 002081B3 40208233 0020F2B3 0020E333 0020C3B3 00111433
001154B3 40115533 001125B3 00113633
00000000 00000001 00000007  00000004 00000002 FFFFFFFD  00000008 00000003 00000004
0000000C 00000004 0000000A  00000010 00000005 00000005  00000014 00000006 FFFFFFFF
00000018 00000007 FFFFFFFA  0000001C 00000008 FFFFFE80  00000020 00000009 01FFFFFF
00000024 0000000A FFFFFFFF  00000028 0000000B 00000001  0000002C 0000000C 00000000
// IIMM: I-type immediates, shifts and SRAI sign
49494D4D 0000000A 0000000A 00000001
FFF00093 7F00F113 80006193 FFF14213 0011A293 0011B313 00409393 0081D413
4081D493 00518513
00000000 00000001 FFFFFFFF  00000004 00000002 000007F0  00000008 00000003 FFFFF800
0000000C 00000004 FFFFF80F  00000010 00000005 00000001  00000014 00000006 00000000
00000018 00000007 FFFFFFF0  0000001C 00000008 00FFFFF8  00000020 00000009 FFFFFFF8
00000024 0000000A FFFFF805
// UPPR: LUI and AUIPC
55505052 00000005 00000005 00000001
123450B7 00010117 FFFFF1B7 80000217 67808293
00000000 00000001 12345000  00000004 00000002 00010004  00000008 00000003 FFFFF000
0000000C 00000004 8000000C  00000010 00000005 12345678
// BRCH: six conditions, not taken then taken, each skips one marker
42524348 0000001B 00000009 00000001
FFF00093 00100113 00208463 00100513 00108463 00200513 00109463 00300513
00209463 00400513 00114463 00500513 0020C463 00600513 0020D463 00700513
00115463 00800513 0020E463 00900513 00116463 00A00513 00117463 00B00513
0020F463 00C00513 00D00593
00000000 00000001 FFFFFFFF  00000004 00000002 00000001  0000000C 0000000A 00000001
0000001C 0000000A 00000003  0000002C 0000000A 00000005  0000003C 0000000A 00000007
0000004C 0000000A 00000009  0000005C 0000000A 0000000B  00000068 0000000B 0000000D
// JUMP: JAL, JALR with odd target, JAL to x0
4A554D50 0000000E 00000006 00000001
00C000EF 00100293 00200293 01D00313 000303E7 00300293 00400293 00800413
010304E7 00500293 00600293 0080006F 00700293 06400513
00000000 00000001 00000004  0000000C 00000006 0000001D  00000010 00000007 00000014
0000001C 00000008 00000008  00000020 00000009 00000024  00000034 0000000A 00000064
// XZER: writes to x0 vanish, reads of x0 give zero, run twice
585A4552 00000005 00000003 00000002
00700013 000002B3 00300313 ABCDE037 006063B3
00000004 00000005 00000000  00000008 00000006 00000003  00000010 00000007 00000003
00000000

/* all.f */
+incdir+rtl
rtl/rv_isa_pkg.sv
rtl/core_pkg.sv
rtl/decode_if.sv
rtl/reg_file.sv
rtl/fetch_unit.sv
rtl/decode_unit.sv
rtl/execute_unit.sv
rtl/rv_core_top.sv
verif/tb_clock_gen.sv
verif/tb_rv_core.sv

/* Makefile */
VERILATOR ?= verilator
TOP       ?= tb_rv_core
FILELIST  ?= all.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing -Wno-fatal

SIM = $(BUILD_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(BUILD_DIR) -o V$(TOP)

run: compile
	./$(SIM) | tee $(LOG)
	grep -q '^>>> PASS$$' $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
